/* all.f */
+incdir+include
hw/msx_bus_pkg.sv
hw/msx_map_pkg.sv
hw/bus_control.sv
hw/slot_select.sv
hw/mapper_segments.sv
hw/sdram_address_map.sv
hw/msx_memory_map.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_top.sv

/* Makefile */
# Verilator simulation of the MSX memory map testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f all.f --top-module tb_top -Mdir obj_dir -o tb_top_sim

run: compile
	./obj_dir/tb_top_sim > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* sim/tb_top.sv */
// ---------------------------------------------------------------------
// Testbench top: DUT, clock, checker, seeded random CPU cycles and an
// in-order SDRAM responder with 1 to 6 cycles of latency
// Inputs change on the falling edge, the run ends with a summary line
// ---------------------------------------------------------------------
`default_nettype none

module tb_top;
	localparam int NUM_CYCLES	= 400;
	localparam int CYCLE_LIMIT	= NUM_CYCLES * 20 + 200;

	wire							clk42m;
	wire							ff_reset_n;
	logic							bus_valid;
	logic							bus_io;
	logic							bus_write;
	msx_bus_pkg::cpu_addr_t			bus_addr;
	msx_bus_pkg::cpu_data_t			bus_wdata;
	wire							bus_done;
	wire msx_bus_pkg::cpu_data_t	bus_rdata;
	wire							mem_req_valid;
	wire							mem_req_write;
	wire msx_map_pkg::sdram_addr_t	mem_req_addr;
	wire msx_bus_pkg::cpu_data_t	mem_req_wdata;
	logic							mem_credit = 1'b0;
	logic							mem_rdata_valid = 1'b0;
	msx_bus_pkg::cpu_data_t			mem_rdata = 8'h00;

	integer			stim_seed;
	integer			resp_seed;
	int				cycle_count = 0;
	int				issued = 0;			// Bus cycles started
	int				cycles_done;
	int				requests_seen;
	int				value_errors;
	int				protocol_errors;
	int				pend_due [$];		// Completion cycle per request
	logic			pend_write [$];
	logic [22:0]	pend_addr [$];
	int				last_due = 0;

	tb_clock u_clock (
		.clk42m		( clk42m		),
		.ff_reset_n	( ff_reset_n	)
	);

	msx_memory_map u_dut (
		.clk42m				( clk42m			),
		.ff_reset_n			( ff_reset_n		),
		.bus_valid			( bus_valid			),
		.bus_io				( bus_io			),
		.bus_write			( bus_write			),
		.bus_addr			( bus_addr			),
		.bus_wdata			( bus_wdata			),
		.bus_done			( bus_done			),
		.bus_rdata			( bus_rdata			),
		.mem_req_valid		( mem_req_valid		),
		.mem_req_write		( mem_req_write		),
		.mem_req_addr		( mem_req_addr		),
		.mem_req_wdata		( mem_req_wdata		),
		.mem_credit			( mem_credit		),
		.mem_rdata_valid	( mem_rdata_valid	),
		.mem_rdata			( mem_rdata			)
	);

	tb_checker u_check (
		.clk42m				( clk42m			),
		.ff_reset_n			( ff_reset_n		),
		.bus_valid			( bus_valid			),
		.bus_io				( bus_io			),
		.bus_write			( bus_write			),
		.bus_addr			( bus_addr			),
		.bus_wdata			( bus_wdata			),
		.bus_done			( bus_done			),
		.bus_rdata			( bus_rdata			),
		.mem_req_valid		( mem_req_valid		),
		.mem_req_write		( mem_req_write		),
		.mem_req_addr		( mem_req_addr		),
		.mem_req_wdata		( mem_req_wdata		),
		.mem_credit			( mem_credit		),
		.cycles_done		( cycles_done		),
		.requests_seen		( requests_seen		),
		.value_errors		( value_errors		),
		.protocol_errors	( protocol_errors	)
	);

	// Read data of the SDRAM model
	function automatic logic [7:0] sdram_pattern(input logic [22:0] addr);
		return addr[7:0] ^ addr[20:13];
	endfunction

	// ---------------------------------------------------------------------
	// SDRAM responder, completes in request order
	// ---------------------------------------------------------------------
	always @(negedge clk42m) begin
		int delay;
		int due;
		mem_credit		= 1'b0;
		mem_rdata_valid	= 1'b0;
		if (ff_reset_n) begin
			if (mem_req_valid) begin
				delay	= 1 + ({$random(resp_seed)} % 6);
				due		= cycle_count + delay;
				if (due <= last_due) begin
					due = last_due + 1;			// One completion per cycle
				end
				last_due = due;
				pend_due.push_back(due);
				pend_write.push_back(mem_req_write);
				pend_addr.push_back(mem_req_addr);
			end
			if ((pend_due.size() != 0) && (pend_due[0] <= cycle_count)) begin
				mem_credit = 1'b1;
				if (!pend_write[0]) begin
					mem_rdata_valid	= 1'b1;
					mem_rdata		= sdram_pattern(pend_addr[0]);
				end
				pend_due.delete(0);
				pend_write.delete(0);
				pend_addr.delete(0);
			end
		end
	end

	// One CPU cycle, held until bus_done has been seen
	task automatic bus_cycle(input logic io, input logic write,
			input logic [15:0] addr, input logic [7:0] wdata);
		bus_valid	= 1'b1;
		bus_io		= io;
		bus_write	= write;
		bus_addr	= addr;
		bus_wdata	= wdata;
		issued++;
		@(negedge clk42m);
		while (!bus_done) begin
			@(negedge clk42m);
		end
		@(negedge clk42m);			// Done cycle is over
		bus_valid	= 1'b0;
	endtask

	// Weighted toward the registers and the slots with memory behind them
	task automatic random_access();
		logic [3:0]		kind;
		logic			write;
		logic [15:0]	addr;
		logic [7:0]		wdata;
		int				gap;
		kind	= 4'($random(stim_seed));
		write	= 1'($random(stim_seed));
		addr	= 16'($random(stim_seed));
		wdata	= 8'($random(stim_seed));
		gap		= {$random(stim_seed)} % 3;
		repeat (gap) @(negedge clk42m);
		case (kind)
			4'd0: bus_cycle(1'b1, write, {addr[15:8], 8'hA8}, {{2{wdata[7]}}, {2{wdata[5]}},
				{2{wdata[3]}}, {2{wdata[1]}}});		// Slots 0 and 3 only
			4'd1: bus_cycle(1'b1, write, {addr[15:8], 8'hA8}, wdata);
			4'd2, 4'd3: bus_cycle(1'b1, write, {addr[15:8], 6'h3F, addr[1:0]}, wdata);
			4'd4, 4'd5: bus_cycle(1'b0, write, 16'hFFFF, wdata);
			4'd6: bus_cycle(1'b1, write, addr, wdata);		// Any port
			default: bus_cycle(1'b0, write, addr, wdata);
		endcase
	endtask

	// ---------------------------------------------------------------------
	// Stimulus
	// ---------------------------------------------------------------------
	initial begin
		stim_seed	= 32'h4338a432;
		resp_seed	= ~32'h4338a432;		// Separate stream for latencies
		bus_valid	= 1'b0;
		bus_io		= 1'b0;
		bus_write	= 1'b0;
		bus_addr	= '0;
		bus_wdata	= '0;
		@(posedge ff_reset_n);
		@(negedge clk42m);
		// Reset values of the slot and mapper registers
		bus_cycle(1'b1, 1'b0, 16'h00A8, 8'h00);
		for (int p = 0; p < 4; p++) begin
			bus_cycle(1'b1, 1'b0, 16'h00FC + 16'(p), 8'h00);
		end
		for (int n = 0; n < NUM_CYCLES; n++) begin
			random_access();
		end
		while (pend_due.size() != 0) begin
			@(negedge clk42m);		// Posted writes drain
		end
		repeat (4) @(negedge clk42m);
		if (cycles_done != issued) begin
			$display("Bus cycles ended %0d times for %0d cycles started", cycles_done, issued);
		end
		$display("Summary: %0d bus cycles, %0d requests, %0d value errors, %0d protocol errors",
			cycles_done, requests_seen, value_errors, protocol_errors);
		if ((value_errors == 0) && (protocol_errors == 0) && (cycles_done == issued)) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Cycle counter and timeout
	always @(posedge clk42m) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
			$display("Testbench failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* sim/tb_checker.sv */
// ---------------------------------------------------------------------
// Testbench checker: mirrors the slot, subslot and mapper registers
// and the SDRAM bank map, compares every request and every read byte
// Samples on the rising edge, the DUT inputs settle at the falling one
// ---------------------------------------------------------------------
`default_nettype none
`include "msx_map_config.svh"

module tb_checker (
	input	wire			clk42m,
	input	wire			ff_reset_n,
	input	wire			bus_valid,
	input	wire			bus_io,
	input	wire			bus_write,
	input	wire [15:0]		bus_addr,
	input	wire [7:0]		bus_wdata,
	input	wire			bus_done,
	input	wire [7:0]		bus_rdata,
	input	wire			mem_req_valid,
	input	wire			mem_req_write,
	input	wire [22:0]		mem_req_addr,
	input	wire [7:0]		mem_req_wdata,
	input	wire			mem_credit,
	output	int				cycles_done,
	output	int				requests_seen,
	output	int				value_errors,
	output	int				protocol_errors
);
	logic [7:0]		primary;			// Model of port A8h
	logic [7:0]		sec0;				// Subslots of slot 0
	logic [7:0]		sec3;				// Subslots of slot 3
	logic [7:0]		segment [4];
	logic			busy;				// Bus cycle in progress
	logic			req_due;			// SDRAM request still owed
	logic			cyc_io;
	logic			cyc_write;
	logic			cyc_sslot;			// FFFFh register in expanded slot
	logic [15:0]	cyc_addr;
	logic [7:0]		cyc_wdata;
	logic [22:0]	exp_addr;
	logic [7:0]		exp_rdata;
	int				outstanding;		// Requests without credit back

	// Responder pattern, address low byte XOR bank
	function automatic logic [7:0] sdram_byte(input logic [22:0] addr);
		return addr[7:0] ^ addr[20:13];
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			value_errors++;
			$display("** Error: %s expected 0x%0h, got 0x%0h at time %0t",
				name, expected, actual, $time);
		end
	endtask

	// ---------------------------------------------------------------------
	// Expected answer of the cycle just accepted
	// ---------------------------------------------------------------------
	task automatic predict();
		logic [1:0]	page;
		logic [1:0]	slot;
		logic [1:0]	sub;
		logic [9:0]	bank;
		logic		mapped;
		logic		writable;
		page		= cyc_addr[15:14];
		slot		= primary[{page, 1'b0} +: 2];
		sub			= (slot == 2'd0) ? sec0[{page, 1'b0} +: 2] :
					  (slot == 2'd3) ? sec3[{page, 1'b0} +: 2] : 2'd0;
		mapped		= 1'b1;
		writable	= 1'b0;
		bank		= '0;
		if ((slot == 2'd3) && (sub == 2'd0)) begin
			// Two 8 KB banks per 16 KB segment
			bank = `MAPPER_BANK_BASE + {1'b0, segment[page], 1'b0} + {9'd0, cyc_addr[13]};
			writable = 1'b1;
		end else if ((slot == 2'd0) && (sub == 2'd0) && (page <= 2'd1)) begin
			bank = `MAIN_ROM_BANK + {8'd0, cyc_addr[14:13]};
		end else if ((slot == 2'd0) && (sub == 2'd2) && (page == 2'd1)) begin
			bank = `MUSIC_BANK + {9'd0, cyc_addr[13]};
		end else if ((slot == 2'd3) && (sub == 2'd1) && (page == 2'd0)) begin
			bank = `SUB_ROM_BANK + {9'd0, cyc_addr[13]};
		end else begin
			mapped = 1'b0;
		end
		cyc_sslot	= !cyc_io && (cyc_addr == `SSLOT_REG_ADDR) &&
					  ((primary[7:6] == 2'd0) || (primary[7:6] == 2'd3));
		req_due		= 1'b0;
		exp_rdata	= `UNMAPPED_DATA;
		if (cyc_io) begin
			if (cyc_addr[7:0] == `PPI_SLOT_PORT) begin
				exp_rdata = primary;
			end else if ((cyc_addr[7:0] & 8'hFC) == `MAPPER_PORT_BASE) begin
				exp_rdata = segment[cyc_addr[1:0]];
			end
		end else if (cyc_sslot) begin
			exp_rdata = (primary[7:6] == 2'd3) ? ~sec3 : ~sec0;	// Reads back inverted
		end else if (mapped && (!cyc_write || writable)) begin
			req_due		= 1'b1;
			exp_addr	= {bank, cyc_addr[12:0]};
			exp_rdata	= sdram_byte(exp_addr);
		end
	endtask

	// Register writes take effect when the cycle ends
	task automatic apply_write();
		if (cyc_io && (cyc_addr[7:0] == `PPI_SLOT_PORT)) begin
			primary = cyc_wdata;
		end else if (cyc_io && ((cyc_addr[7:0] & 8'hFC) == `MAPPER_PORT_BASE)) begin
			segment[cyc_addr[1:0]] = cyc_wdata;
		end else if (cyc_sslot && (primary[7:6] == 2'd3)) begin
			sec3 = cyc_wdata;
		end else if (cyc_sslot) begin
			sec0 = cyc_wdata;
		end
	endtask

	// ---------------------------------------------------------------------
	// Compare on every rising edge
	// ---------------------------------------------------------------------
	always @(posedge clk42m) begin
		if (!ff_reset_n) begin
			primary			= '0;
			sec0			= '0;
			sec3			= '0;
			for (int i = 0; i < 4; i++) begin
				segment[i] = 8'(3 - i);		// Page p holds 3 - p
			end
			busy			= 1'b0;
			req_due			= 1'b0;
			outstanding		= 0;
			cycles_done		= 0;
			requests_seen	= 0;
			value_errors	= 0;
			protocol_errors	= 0;
		end else begin
			if (mem_req_valid) begin
				requests_seen++;
				outstanding++;
				if (!req_due) begin
					protocol_errors++;
					$display("Unexpected SDRAM request to 0x%06h at time %0t",
						mem_req_addr, $time);
				end else begin
					check_value("mem_req_write", 32'(cyc_write), 32'(mem_req_write));
					check_value("mem_req_addr", 32'(exp_addr), 32'(mem_req_addr));
					if (cyc_write) begin
						check_value("mem_req_wdata", 32'(cyc_wdata), 32'(mem_req_wdata));
					end
					req_due = 1'b0;
				end
			end
			if (mem_credit) begin
				outstanding--;
			end
			if (outstanding > `MEM_CREDITS) begin
				protocol_errors++;
				$display("More than %0d SDRAM requests outstanding at time %0t",
					`MEM_CREDITS, $time);
			end
			// Bus side, one bus_done per accepted cycle
			if (bus_done) begin
				if (!busy) begin
					protocol_errors++;
					$display("bus_done without an open bus cycle at time %0t", $time);
				end else begin
					cycles_done++;
					if (req_due) begin
						protocol_errors++;
						$display("Bus cycle at 0x%04h ended without its SDRAM request", cyc_addr);
						req_due = 1'b0;
					end
					if (cyc_write) begin
						apply_write();
					end else begin
						check_value("bus_rdata", 32'(exp_rdata), 32'(bus_rdata));
					end
					busy = 1'b0;
				end
			end else if (bus_valid && !busy) begin
				cyc_io		= bus_io;
				cyc_write	= bus_write;
				cyc_addr	= bus_addr;
				cyc_wdata	= bus_wdata;
				predict();
				busy		= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
// ---------------------------------------------------------------------
// Testbench clock and reset: clk42m with a period of 20, ff_reset_n
// low for the first 10 cycles, released on a falling edge
// ---------------------------------------------------------------------
`default_nettype none

module tb_clock (
	output	logic	clk42m,
	output	logic	ff_reset_n
);
	localparam int RESET_CYCLES = 10;

	initial begin
		clk42m = 1'b0;
		forever #10 clk42m = ~clk42m;		// Half period
	end

	initial begin
		ff_reset_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk42m);
		ff_reset_n = 1'b1;
	end

endmodule

`default_nettype wire

/* hw/msx_memory_map.sv */
// ---------------------------------------------------------------------
// Memory-side glue of the MSX: CPU cycle port in, SDRAM request port
// out, slot and mapper registers in between
// Top level of the design, wiring of the four blocks only
// ---------------------------------------------------------------------
`default_nettype none

module msx_memory_map (
	input	wire						clk42m,
	input	wire						ff_reset_n,
	// CPU cycle port
	input	wire						bus_valid,
	input	wire						bus_io,
	input	wire						bus_write,
	input	wire msx_bus_pkg::cpu_addr_t	bus_addr,
	input	wire msx_bus_pkg::cpu_data_t	bus_wdata,
	output	wire						bus_done,
	output	wire msx_bus_pkg::cpu_data_t	bus_rdata,
	// SDRAM request port
	output	wire						mem_req_valid,
	output	wire						mem_req_write,
	output	wire msx_map_pkg::sdram_addr_t	mem_req_addr,
	output	wire msx_bus_pkg::cpu_data_t	mem_req_wdata,
	input	wire						mem_credit,
	input	wire						mem_rdata_valid,
	input	wire msx_bus_pkg::cpu_data_t	mem_rdata
);
	wire						w_reg_wr;
	wire						w_slot_reg_hit;
	wire msx_bus_pkg::cpu_data_t	w_slot_reg_rdata;
	wire						w_map_reg_hit;
	wire msx_bus_pkg::cpu_data_t	w_map_reg_rdata;
	wire msx_map_pkg::slot_num_t	w_page_slot;
	wire msx_map_pkg::slot_num_t	w_page_sub;
	wire msx_map_pkg::segment_t		w_page_segment;
	wire msx_map_pkg::sdram_addr_t	w_mem_addr;
	wire						w_region_mapped;
	wire						w_region_writable;

	// ---------------------------------------------------------------------
	// Cycle control
	// ---------------------------------------------------------------------
	bus_control u_bus_control (
		.clk42m				( clk42m			),
		.ff_reset_n			( ff_reset_n		),
		.bus_valid			( bus_valid			),
		.bus_io				( bus_io			),
		.bus_write			( bus_write			),
		.bus_wdata			( bus_wdata			),
		.bus_done			( bus_done			),
		.bus_rdata			( bus_rdata			),
		.mem_req_valid		( mem_req_valid		),
		.mem_req_write		( mem_req_write		),
		.mem_req_addr		( mem_req_addr		),
		.mem_req_wdata		( mem_req_wdata		),
		.mem_credit			( mem_credit		),
		.mem_rdata_valid	( mem_rdata_valid	),
		.mem_rdata			( mem_rdata			),
		.reg_wr				( w_reg_wr			),
		.slot_reg_hit		( w_slot_reg_hit	),
		.map_reg_hit		( w_map_reg_hit		),
		.slot_reg_rdata		( w_slot_reg_rdata	),
		.map_reg_rdata		( w_map_reg_rdata	),
		.mem_addr			( w_mem_addr		),
		.region_mapped		( w_region_mapped	),
		.region_writable	( w_region_writable	)
	);

	// ---------------------------------------------------------------------
	// Slot and mapper registers
	// ---------------------------------------------------------------------
	slot_select u_slot_select (
		.clk42m				( clk42m			),
		.ff_reset_n			( ff_reset_n		),
		.reg_wr				( w_reg_wr			),
		.bus_io				( bus_io			),
		.bus_addr			( bus_addr			),
		.bus_wdata			( bus_wdata			),
		.page_slot			( w_page_slot		),
		.page_sub			( w_page_sub		),
		.slot_reg_hit		( w_slot_reg_hit	),
		.slot_reg_rdata		( w_slot_reg_rdata	)
	);

	mapper_segments u_mapper_segments (
		.clk42m				( clk42m			),
		.ff_reset_n			( ff_reset_n		),
		.reg_wr				( w_reg_wr			),
		.bus_io				( bus_io			),
		.bus_addr			( bus_addr			),
		.bus_wdata			( bus_wdata			),
		.page_segment		( w_page_segment	),
		.map_reg_hit		( w_map_reg_hit		),
		.map_reg_rdata		( w_map_reg_rdata	)
	);

	// Slot/page to SDRAM translation
	sdram_address_map u_sdram_address_map (
		.bus_addr			( bus_addr			),
		.page_slot			( w_page_slot		),
		.page_sub			( w_page_sub		),
		.page_segment		( w_page_segment	),
		.mem_addr			( w_mem_addr		),
		.region_mapped		( w_region_mapped	),
		.region_writable	( w_region_writable	)
	);

endmodule

`default_nettype wire

/* hw/sdram_address_map.sv */
// ---------------------------------------------------------------------
// Slot, subslot and page to SDRAM bank translation
// Purely combinational, also flags mapped and writable regions
// ---------------------------------------------------------------------
`default_nettype none
`include "msx_map_config.svh"

module sdram_address_map (
	input	wire msx_bus_pkg::cpu_addr_t	bus_addr,
	input	wire msx_map_pkg::slot_num_t	page_slot,
	input	wire msx_map_pkg::slot_num_t	page_sub,
	input	wire msx_map_pkg::segment_t		page_segment,
	output	msx_map_pkg::sdram_addr_t	mem_addr,
	output	logic						region_mapped,
	output	logic						region_writable
);
	logic [1:0]					w_page;
	msx_map_pkg::sdram_bank_t	w_bank;

	assign w_page = bus_addr[15:14];

	always_comb begin
		w_bank			= '0;
		region_mapped	= 1'b0;
		region_writable	= 1'b0;
		if ((page_slot == 2'd3) && (page_sub == 2'd0)) begin
			// Mapper RAM, 2 banks per segment, all pages
			w_bank			= `MAPPER_BANK_BASE + {1'b0, page_segment, bus_addr[13]};
			region_mapped	= 1'b1;
			region_writable	= 1'b1;
		end else if ((page_slot == 2'd0) && (page_sub == 2'd0) && !w_page[1]) begin
			w_bank			= `MAIN_ROM_BANK + {8'd0, bus_addr[14:13]};	// 32 KB at 0000h
			region_mapped	= 1'b1;
		end else if ((page_slot == 2'd0) && (page_sub == 2'd2) && (w_page == 2'd1)) begin
			w_bank			= `MUSIC_BANK + {9'd0, bus_addr[13]};		// MSX-MUSIC at 4000h
			region_mapped	= 1'b1;
		end else if ((page_slot == 2'd3) && (page_sub == 2'd1) && (w_page == 2'd0)) begin
			w_bank			= `SUB_ROM_BANK + {9'd0, bus_addr[13]};	// SUB-ROM at 0000h
			region_mapped	= 1'b1;
		end
	end

	// Bank on top, offset inside the 8 KB bank below
	assign mem_addr = {w_bank, bus_addr[12:0]};

endmodule

`default_nettype wire

/* hw/mapper_segments.sv */
// ---------------------------------------------------------------------
// Memory mapper segment registers at I/O ports FCh to FFh, one per
// 16 KB page, with readback and the segment of the current access
// ---------------------------------------------------------------------
`default_nettype none
`include "msx_map_config.svh"

module mapper_segments (
	input	wire						clk42m,
	input	wire						ff_reset_n,
	input	wire						reg_wr,
	input	wire						bus_io,
	input	wire msx_bus_pkg::cpu_addr_t	bus_addr,
	input	wire msx_bus_pkg::cpu_data_t	bus_wdata,
	output	msx_map_pkg::segment_t		page_segment,
	output	logic						map_reg_hit,
	output	msx_bus_pkg::cpu_data_t		map_reg_rdata
);
	msx_map_pkg::segment_t		ff_segment [4];		// Indexed by page
	logic						w_port_hit;

	// FCh..FFh, low two bits select the page
	assign w_port_hit = bus_io && ({bus_addr[7:2], 2'b00} == `MAPPER_PORT_BASE);

	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			for (int i = 0; i < 4; i++) begin
				ff_segment[i] <= msx_map_pkg::segment_t'(3 - i);	// 3,2,1,0
			end
		end else if (reg_wr && w_port_hit) begin
			ff_segment[bus_addr[1:0]] <= bus_wdata;
		end
	end

	assign map_reg_hit		= w_port_hit;
	assign map_reg_rdata	= ff_segment[bus_addr[1:0]];

	// Segment behind the memory page being accessed
	assign page_segment		= ff_segment[bus_addr[15:14]];

endmodule

`default_nettype wire

/* hw/slot_select.sv */
// ---------------------------------------------------------------------
// Primary slot register at port A8h and secondary slot registers of
// expanded slots 0 and 3 at FFFFh, with the slot lookup per access
// ---------------------------------------------------------------------
`default_nettype none
`include "msx_map_config.svh"

module slot_select (
	input	wire						clk42m,
	input	wire						ff_reset_n,
	input	wire						reg_wr,
	input	wire						bus_io,
	input	wire msx_bus_pkg::cpu_addr_t	bus_addr,
	input	wire msx_bus_pkg::cpu_data_t	bus_wdata,
	output	msx_map_pkg::slot_num_t		page_slot,
	output	msx_map_pkg::slot_num_t		page_sub,
	output	logic						slot_reg_hit,
	output	msx_bus_pkg::cpu_data_t		slot_reg_rdata
);
	msx_bus_pkg::cpu_data_t		ff_primary;		// Two bits per page
	msx_bus_pkg::cpu_data_t		ff_sec0;		// Subslots of slot 0
	msx_bus_pkg::cpu_data_t		ff_sec3;		// Subslots of slot 3

	logic [2:0]					w_pair;			// Bit pair index of this page
	msx_map_pkg::slot_num_t		w_page3_slot;
	msx_bus_pkg::cpu_data_t		w_page3_sec;
	logic						w_ppi_hit;
	logic						w_sslot_hit;

	assign w_pair = {bus_addr[15:14], 1'b0};
	assign page_slot = ff_primary[w_pair +: 2];

	// Subslot only in expanded slots
	always_comb begin
		case (page_slot)
			2'd0:		page_sub = ff_sec0[w_pair +: 2];
			2'd3:		page_sub = ff_sec3[w_pair +: 2];
			default:	page_sub = 2'd0;
		endcase
	end

	// FFFFh belongs to whatever slot page 3 points at
	assign w_page3_slot	= ff_primary[7:6];
	assign w_page3_sec	= (w_page3_slot == 2'd3) ? ff_sec3 : ff_sec0;

	assign w_ppi_hit	= bus_io && (bus_addr[7:0] == `PPI_SLOT_PORT);
	assign w_sslot_hit	= !bus_io && (bus_addr == `SSLOT_REG_ADDR) &&
						  ((w_page3_slot == 2'd0) || (w_page3_slot == 2'd3));

	assign slot_reg_hit		= w_ppi_hit || w_sslot_hit;
	assign slot_reg_rdata	= w_ppi_hit ? ff_primary : ~w_page3_sec;	// Secondary reads inverted

	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_primary	<= '0;
			ff_sec0		<= '0;
			ff_sec3		<= '0;
		end else if (reg_wr) begin
			if (w_ppi_hit) begin
				ff_primary <= bus_wdata;
			end
			if (w_sslot_hit && (w_page3_slot == 2'd3)) begin
				ff_sec3 <= bus_wdata;
			end else if (w_sslot_hit) begin
				ff_sec0 <= bus_wdata;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/bus_control.sv */
// ---------------------------------------------------------------------
// CPU cycle FSM: answers register and unmapped cycles locally, sends
// mapped cycles to the SDRAM request port under credit flow control
// Writes are posted, reads wait for their data before bus_done
// ---------------------------------------------------------------------
`default_nettype none
`include "msx_map_config.svh"

module bus_control (
	input	wire						clk42m,
	input	wire						ff_reset_n,
	// CPU cycle port
	input	wire						bus_valid,
	input	wire						bus_io,
	input	wire						bus_write,
	input	wire msx_bus_pkg::cpu_data_t	bus_wdata,
	output	logic						bus_done,
	output	msx_bus_pkg::cpu_data_t		bus_rdata,
	// SDRAM request port
	output	logic						mem_req_valid,
	output	logic						mem_req_write,
	output	msx_map_pkg::sdram_addr_t	mem_req_addr,
	output	msx_bus_pkg::cpu_data_t		mem_req_wdata,
	input	wire						mem_credit,
	input	wire						mem_rdata_valid,
	input	wire msx_bus_pkg::cpu_data_t	mem_rdata,
	// Register blocks and address map
	output	logic						reg_wr,
	input	wire						slot_reg_hit,
	input	wire						map_reg_hit,
	input	wire msx_bus_pkg::cpu_data_t	slot_reg_rdata,
	input	wire msx_bus_pkg::cpu_data_t	map_reg_rdata,
	input	wire msx_map_pkg::sdram_addr_t	mem_addr,
	input	wire						region_mapped,
	input	wire						region_writable
);
	localparam logic [`CREDIT_W-1:0] CREDIT_INIT = `MEM_CREDITS;

	msx_bus_pkg::ctrl_state_t	ff_state;
	logic [`CREDIT_W-1:0]		ff_credits;		// Credits held
	logic						ff_reg_wr;
	logic						ff_req_valid;
	logic						ff_req_write;
	msx_map_pkg::sdram_addr_t	ff_req_addr;
	msx_bus_pkg::cpu_data_t		ff_req_wdata;
	msx_bus_pkg::cpu_data_t		ff_rdata;

	logic						w_start;
	logic						w_reg_cycle;
	logic						w_mem_cycle;
	logic						w_credit_ok;
	logic						w_issue;
	msx_bus_pkg::cpu_data_t		w_local_rdata;

	// ---------------------------------------------------------------------
	// Cycle classification
	// ---------------------------------------------------------------------
	assign w_start		= (ff_state == msx_bus_pkg::ST_IDLE) && bus_valid;
	assign w_reg_cycle	= bus_io || slot_reg_hit;		// Any I/O, or FFFFh in expanded slot
	assign w_mem_cycle	= !w_reg_cycle && region_mapped && (!bus_write || region_writable);
	assign w_credit_ok	= (ff_credits != '0);

	// One request per cycle, first try or after a stall
	assign w_issue		= w_mem_cycle && w_credit_ok &&
						  (w_start || (ff_state == msx_bus_pkg::ST_WAIT_CREDIT));

	// Local readback, idle bus otherwise
	assign w_local_rdata	= slot_reg_hit	? slot_reg_rdata :
							  map_reg_hit	? map_reg_rdata :
											  `UNMAPPED_DATA;

	// ---------------------------------------------------------------------
	// FSM
	// ---------------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_state		<= msx_bus_pkg::ST_IDLE;
			ff_reg_wr		<= 1'b0;
			ff_req_valid	<= 1'b0;
		end else begin
			ff_reg_wr		<= w_start && bus_write;	// Blocks qualify with own hit
			ff_req_valid	<= w_issue;
			case (ff_state)
				msx_bus_pkg::ST_IDLE: begin
					if (bus_valid) begin
						if (!w_mem_cycle) begin
							ff_state <= msx_bus_pkg::ST_REG_RESP;
						end else if (!w_credit_ok) begin
							ff_state <= msx_bus_pkg::ST_WAIT_CREDIT;	// Back-pressure
						end else if (bus_write) begin
							ff_state <= msx_bus_pkg::ST_DONE;			// Posted
						end else begin
							ff_state <= msx_bus_pkg::ST_WAIT_RDATA;
						end
					end
				end
				msx_bus_pkg::ST_WAIT_CREDIT: begin
					if (w_credit_ok) begin
						ff_state <= bus_write ? msx_bus_pkg::ST_DONE : msx_bus_pkg::ST_WAIT_RDATA;
					end
				end
				msx_bus_pkg::ST_WAIT_RDATA: begin
					if (mem_rdata_valid) begin
						ff_state <= msx_bus_pkg::ST_DONE;
					end
				end
				default: begin
					ff_state <= msx_bus_pkg::ST_IDLE;	// REG_RESP and DONE last one cycle
				end
			endcase
		end
	end

	// Credit counter, one down per issue, one up per returned credit
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_credits <= CREDIT_INIT;
		end else if (w_issue && !mem_credit) begin
			ff_credits <= ff_credits - 1'b1;
		end else if (!w_issue && mem_credit) begin
			ff_credits <= ff_credits + 1'b1;
		end
	end

	// Request payload and returned byte
	always_ff @(posedge clk42m) begin
		if (w_issue) begin
			ff_req_write	<= bus_write;
			ff_req_addr		<= mem_addr;
			ff_req_wdata	<= bus_wdata;
		end
		if (w_start && !w_mem_cycle) begin
			ff_rdata <= w_local_rdata;
		end else if ((ff_state == msx_bus_pkg::ST_WAIT_RDATA) && mem_rdata_valid) begin
			ff_rdata <= mem_rdata;		// In order, so this is ours
		end
	end

	assign bus_done			= (ff_state == msx_bus_pkg::ST_REG_RESP) ||
							  (ff_state == msx_bus_pkg::ST_DONE);
	assign bus_rdata		= ff_rdata;
	assign reg_wr			= ff_reg_wr;
	assign mem_req_valid	= ff_req_valid;
	assign mem_req_write	= ff_req_write;
	assign mem_req_addr		= ff_req_addr;
	assign mem_req_wdata	= ff_req_wdata;

endmodule

`default_nettype wire

/* hw/msx_map_pkg.sv */
// ---------------------------------------------------------------------
// Types of the MSX memory map: slots, mapper segments and the SDRAM
// address space behind them
// Referenced with scoped names by the slot, mapper and address blocks
// ---------------------------------------------------------------------
`default_nettype none

package msx_map_pkg;

	// Primary slot or subslot number
	typedef logic [1:0]		slot_num_t;

	// Memory mapper segment, 16 KB each
	typedef logic [7:0]		segment_t;

	// 8 KB bank inside the SDRAM
	typedef logic [9:0]		sdram_bank_t;

	// Byte address into the 8 MB SDRAM
	// Bank in [22:13], offset in [12:0]
	typedef logic [22:0]	sdram_addr_t;

endpackage

`default_nettype wire

/* hw/msx_bus_pkg.sv */
// ---------------------------------------------------------------------
// Types of the CPU cycle port and of the bus control FSM
// Referenced with scoped names by the top level and bus_control
// ---------------------------------------------------------------------
`default_nettype none

package msx_bus_pkg;

	typedef logic [15:0]	cpu_addr_t;		// Z80 address, I/O uses low byte
	typedef logic [7:0]		cpu_data_t;		// Z80 data byte

	// Bus control states
	typedef enum logic [2:0] {
		ST_IDLE,							// Waiting for bus_valid
		ST_REG_RESP,						// Local answer, bus_done now
		ST_WAIT_CREDIT,						// Mapped access, no credit held
		ST_WAIT_RDATA,						// Read issued, data pending
		ST_DONE								// SDRAM cycle finished, bus_done now
	} ctrl_state_t;

endpackage

`default_nettype wire

/* include/msx_map_config.svh */
// ---------------------------------------------------------------------
// Constants of the MSX memory-side glue: I/O ports, register address,
// SDRAM bank numbers and the request credit budget
// Included by the RTL blocks that decode or count against them
// ---------------------------------------------------------------------
`ifndef MSX_MAP_CONFIG_SVH
`define MSX_MAP_CONFIG_SVH

// ---------------------------------------------------------------------
// I/O ports and memory-mapped registers
// ---------------------------------------------------------------------
`define PPI_SLOT_PORT		8'hA8		// Primary slot select, PPI port A
`define MAPPER_PORT_BASE	8'hFC		// FCh..FFh, low two bits pick the page
`define SSLOT_REG_ADDR		16'hFFFF	// Secondary slot register in expanded slots

// ---------------------------------------------------------------------
// SDRAM banks, 8 KB each
// ---------------------------------------------------------------------
`define MAIN_ROM_BANK		10'h010		// Slot 0-0, four banks
`define MUSIC_BANK			10'h01A		// Slot 0-2, two banks
`define SUB_ROM_BANK		10'h040		// Slot 3-1, two banks
`define MAPPER_BANK_BASE	10'h200		// Slot 3-0, 256 segments of 16 KB

// ---------------------------------------------------------------------
// Request flow control
// ---------------------------------------------------------------------
`define MEM_CREDITS			2			// Requests in flight at most
`define CREDIT_W			2			// Counter width, holds 0..MEM_CREDITS

// Idle bus value
`define UNMAPPED_DATA		8'hFF

`endif
